// ==== Makefile ====
TOP = fir_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f fir_axis.f \
		--top-module $(TOP) --Mdir obj_dir -o sim_fir
	./obj_dir/sim_fir > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== fir_axis.f ====
+incdir+include
src/fir_cfg_pkg.sv
src/fir_core_pkg.sv
src/fir_axil_regs.sv
src/fir_sequencer.sv
src/fir_mac.sv
src/fir_y_out.sv
src/fir_top.sv
verification/fir_clk_gen.sv
verification/fir_bram_model.sv
verification/fir_sva.sv
verification/fir_tb.sv

// ==== include/fir_consts.svh ====
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------
`define FIR_ADDR_WIDTH 12 // Lite and RAM address
`define FIR_DATA_WIDTH 32 // Sample, tap, register word
`define FIR_NUM_TAPS 11
`define FIR_IDX_WIDTH 4 // Tap or history slot index

// ------------------------------------------------------------------------
// Register map, byte addresses
// ------------------------------------------------------------------------
`define FIR_REG_AP 12'h000 // Control and status
`define FIR_REG_LEN 12'h010 // Samples per run
`define FIR_REG_TAP0 12'h020 // h0
`define FIR_REG_TAP_LAST 12'h048 // h10

`endif

// ==== src/fir_axil_regs.sv ====
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_axil_regs
    import fir_cfg_pkg::*;
    import fir_core_pkg::*;
(
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    // Lite write
    input  logic                       awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0] awaddr,
    input  logic                       wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0] wdata,
    // Lite read
    input  logic                       arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0] araddr,
    input  logic                       rready,
    output logic                       awready,
    output logic                       wready,
    output logic                       arready,
    output logic                       rvalid,
    output logic [`FIR_DATA_WIDTH-1:0] rdata,
    // Engine side
    input  logic [`FIR_DATA_WIDTH-1:0] tap_do,
    input  logic                       tap_rd_seq,
    input  tap_idx_t                   tap_idx_seq,
    input  logic                       run_done,
    input  logic                       ss_tready,
    input  logic                       sm_tvalid,
    output logic                       start,
    output logic [`FIR_DATA_WIDTH-1:0] data_len,
    output logic                       tap_we,
    output logic [`FIR_ADDR_WIDTH-1:0] tap_a,
    output logic [`FIR_DATA_WIDTH-1:0] tap_di
);

    lite_state_t                w_state, r_state;
    logic [`FIR_ADDR_WIDTH-1:0] waddr, raddr; // Captured addresses
    logic                       w_fire;       // Write performed this edge
    logic                       ap_done, ap_idle;
    logic                       x_ready_q, y_valid_q;
    logic [`FIR_DATA_WIDTH-1:0] status;
    tap_idx_t                   lite_idx;

    // Byte address to tap RAM word index
    function automatic tap_idx_t tap_index(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        logic [`FIR_ADDR_WIDTH-1:0] offs;
        offs = addr - `FIR_REG_TAP0;
        return offs[`FIR_IDX_WIDTH+1:2];
    endfunction

    function automatic logic is_tap(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        return (addr >= `FIR_REG_TAP0) && (addr <= `FIR_REG_TAP_LAST);
    endfunction

    // ------------------------------------------------------------------------
    // Lite channel FSMs
    // ------------------------------------------------------------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            w_state <= lite_idle;
            r_state <= lite_idle;
        end else begin
            case (w_state)
                lite_idle: w_state <= lite_addr;
                lite_addr: if (awvalid) w_state <= lite_data;
                default:   if (wvalid) w_state <= lite_idle; // Write on this edge
            endcase
            case (r_state)
                lite_idle: r_state <= lite_addr;
                lite_addr: if (arvalid) r_state <= lite_data;
                default:   if (rready) r_state <= lite_idle; // rvalid held until here
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (w_state == lite_addr && awvalid) waddr <= awaddr;
        if (r_state == lite_addr && arvalid) raddr <= araddr;
    end

    assign awready = (w_state == lite_addr);
    assign wready  = (w_state == lite_data);
    assign arready = (r_state == lite_addr);
    assign rvalid  = (r_state == lite_data);
    assign w_fire  = (w_state == lite_data) && wvalid;

    // ------------------------------------------------------------------------
    // Control, status and length
    // ------------------------------------------------------------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            start     <= 1'b0;
            ap_done   <= 1'b0;
            ap_idle   <= 1'b1;
            data_len  <= '0;
            x_ready_q <= 1'b0;
            y_valid_q <= 1'b0;
        end else begin
            // One-cycle pulse, only accepted while idle
            start <= w_fire && (waddr == `FIR_REG_AP) && wdata[AP_START_BIT] && ap_idle;
            if (run_done)
                ap_idle <= 1'b1;
            else if (start)
                ap_idle <= 1'b0;
            if (run_done)
                ap_done <= 1'b1;
            else if (rvalid && rready && raddr == `FIR_REG_AP)
                ap_done <= 1'b0; // Cleared by reading it
            if (w_fire && waddr == `FIR_REG_LEN)
                data_len <= wdata;
            x_ready_q <= ss_tready;
            y_valid_q <= sm_tvalid;
        end
    end

    always_comb begin
        status               = '0;
        status[AP_START_BIT] = start;
        status[AP_DONE_BIT]  = ap_done;
        status[AP_IDLE_BIT]  = ap_idle;
        status[X_READY_BIT]  = x_ready_q;
        status[Y_VALID_BIT]  = y_valid_q;
        if (raddr == `FIR_REG_AP)
            rdata = status;
        else if (raddr == `FIR_REG_LEN)
            rdata = data_len;
        else if (is_tap(raddr))
            rdata = tap_do; // RAM output, index held through the data phase
        else
            rdata = '0;
    end

    // ------------------------------------------------------------------------
    // Tap RAM port, engine reads win
    // ------------------------------------------------------------------------
    always_comb begin
        if (w_state == lite_data)
            lite_idx = tap_index(waddr);
        else if (r_state == lite_addr)
            lite_idx = tap_index(araddr); // Read issued on the ar handshake
        else
            lite_idx = tap_index(raddr);
    end

    assign tap_a  = {{(`FIR_ADDR_WIDTH-`FIR_IDX_WIDTH){1'b0}},
                     (tap_rd_seq ? tap_idx_seq : lite_idx)};
    assign tap_we = w_fire && is_tap(waddr) && ap_idle; // Taps frozen during a run
    assign tap_di = wdata;

endmodule

// ==== src/fir_cfg_pkg.sv ====
// Register side definitions
package fir_cfg_pkg;

    // Lite channel state, shared by the write and read FSMs
    typedef enum logic [1:0] {
        lite_idle, // One cycle after reset or after a transfer
        lite_addr, // Address ready
        lite_data  // Data phase
    } lite_state_t;

    // Bit positions in the 0x00 register
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;
    // Bit 3 reserved, reads 0
    localparam int X_READY_BIT  = 4;
    localparam int Y_VALID_BIT  = 5;

endpackage

// ==== src/fir_core_pkg.sv ====
`include "fir_consts.svh"

// Datapath definitions
package fir_core_pkg;

    typedef logic [`FIR_DATA_WIDTH-1:0]   sample_t;  // X, Y and tap word
    typedef logic [2*`FIR_DATA_WIDTH-1:0] product_t; // Full width product
    typedef logic [`FIR_IDX_WIDTH-1:0]    tap_idx_t;

    // Engine run states
    typedef enum logic [1:0] {
        wait_start, // Idle until ap_start
        wait_x,     // ss_tready high
        proc,       // Reads and MAC pipeline drain
        flush       // Result ready, output stage still busy
    } eng_state_t;

endpackage

// ==== src/fir_mac.sv ====
`timescale 1ns/1ps

module fir_mac import fir_core_pkg::*; (
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  logic    mac_clear,
    input  logic    mac_en,
    input  sample_t tap_do,
    input  sample_t data_do,
    output sample_t acc
);

    product_t prod;   // Registered h[k] * x[n-k]
    logic     add_en; // prod valid this cycle

    always_ff @(posedge axis_clk) begin
        if (mac_en)
            prod <= product_t'(tap_do) * product_t'(data_do);
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            add_en <= 1'b0;
            acc    <= '0;
        end else begin
            add_en <= mac_en;
            if (mac_clear)
                acc <= '0; // New sample accepted
            else if (add_en)
                acc <= acc + sample_t'(prod); // Low word only, wraps mod 2^32
        end
    end

endmodule

// ==== src/fir_sequencer.sv ====
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_sequencer import fir_core_pkg::*; (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       start,
    input  logic [`FIR_DATA_WIDTH-1:0] data_len,
    input  logic                       ss_tvalid,
    input  sample_t                    ss_tdata,
    input  logic                       y_full,
    output logic                       ss_tready,
    output logic                       tap_rd_seq,
    output tap_idx_t                   tap_idx_seq,
    output logic                       data_we,
    output logic [`FIR_ADDR_WIDTH-1:0] data_a,
    output sample_t                    data_di,
    output logic                       mac_clear,
    output logic                       mac_en,
    output logic                       y_push,
    output logic                       y_last
);

    localparam tap_idx_t num_taps  = tap_idx_t'(`FIR_NUM_TAPS);
    localparam tap_idx_t last_slot = num_taps - 1'b1;

    eng_state_t                 state, state_nx;
    logic                       accept;    // X handshake
    logic                       step_done; // Accumulator final
    logic                       last_q;    // Current sample is the last of the run
    logic [`FIR_DATA_WIDTH-1:0] x_cnt;     // Samples accepted this run
    tap_idx_t                   fill;      // Valid history depth, saturates at 11
    tap_idx_t                   step;      // Cycle within proc
    tap_idx_t                   wptr;      // Next history slot to write
    tap_idx_t                   xptr;      // History slot being read
    tap_idx_t                   x_slot;

    assign accept    = (state == wait_x) && ss_tvalid;
    assign step_done = (step == fill + tap_idx_t'(2)); // Read + product + add stages

    // ------------------------------------------------------------------------
    // Run FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nx = state;
        case (state)
            wait_start: if (start) state_nx = wait_x;
            wait_x:     if (accept) state_nx = proc;
            proc: begin
                if (step_done) begin
                    if (y_full)
                        state_nx = flush; // Output stage still holds a result
                    else
                        state_nx = last_q ? wait_start : wait_x;
                end
            end
            default:    if (!y_full) state_nx = last_q ? wait_start : wait_x;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state  <= wait_start;
            mac_en <= 1'b0;
            last_q <= 1'b0;
            x_cnt  <= '0;
            fill   <= '0;
            step   <= '0;
            wptr   <= '0;
            xptr   <= '0;
        end else begin
            state  <= state_nx;
            mac_en <= tap_rd_seq; // RAM data arrives one cycle after the address
            if (state == wait_start) begin
                if (start) begin // New run, empty history
                    x_cnt <= '0;
                    fill  <= '0;
                    wptr  <= '0;
                end
            end else if (accept) begin
                x_cnt  <= x_cnt + 1'b1;
                last_q <= (x_cnt + 1'b1 == data_len);
                if (fill != num_taps)
                    fill <= fill + 1'b1;
                wptr <= (wptr == last_slot) ? '0 : wptr + 1'b1;
                xptr <= wptr; // First read is the new sample
                step <= '0;
            end else if (state == proc) begin
                step <= step + 1'b1;
                if (tap_rd_seq)
                    xptr <= (xptr == '0) ? last_slot : xptr - 1'b1; // Walk back in time
            end
        end
    end

    // ------------------------------------------------------------------------
    // RAM addressing and engine strobes
    // ------------------------------------------------------------------------
    assign ss_tready   = (state == wait_x);
    assign tap_rd_seq  = (state == proc) && (step < fill); // k = 0 .. n-1
    assign tap_idx_seq = step;

    assign x_slot  = (state == wait_x) ? wptr : xptr;
    assign data_a  = {{(`FIR_ADDR_WIDTH-`FIR_IDX_WIDTH){1'b0}}, x_slot};
    assign data_we = accept; // Sample stored on the acceptance cycle
    assign data_di = ss_tdata;

    assign mac_clear = accept;
    assign y_push    = ((state == proc && step_done) || state == flush) && !y_full;
    assign y_last    = last_q;

endmodule

// ==== src/fir_top.sv ====
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_top import fir_core_pkg::*; (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    // Lite write
    output logic                       awready,
    input  logic                       awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0] awaddr,
    output logic                       wready,
    input  logic                       wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0] wdata,
    // Lite read
    output logic                       arready,
    input  logic                       arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0] araddr,
    input  logic                       rready,
    output logic                       rvalid,
    output logic [`FIR_DATA_WIDTH-1:0] rdata,
    // X stream in
    output logic                       ss_tready,
    input  logic                       ss_tvalid,
    input  sample_t                    ss_tdata,
    // Y stream out
    input  logic                       sm_tready,
    output logic                       sm_tvalid,
    output logic                       sm_tlast,
    output sample_t                    sm_tdata,
    // Tap RAM
    output logic                       tap_we,
    output logic [`FIR_DATA_WIDTH-1:0] tap_di,
    output logic [`FIR_ADDR_WIDTH-1:0] tap_a,
    input  logic [`FIR_DATA_WIDTH-1:0] tap_do,
    // X RAM
    output logic                       data_we,
    output sample_t                    data_di,
    output logic [`FIR_ADDR_WIDTH-1:0] data_a,
    input  sample_t                    data_do
);

    logic                       start, run_done;
    logic [`FIR_DATA_WIDTH-1:0] data_len;
    logic                       tap_rd_seq;
    tap_idx_t                   tap_idx_seq;
    logic                       mac_clear, mac_en;
    logic                       y_push, y_last, y_full;
    sample_t                    acc;

    fir_axil_regs u_regs (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .wvalid, .wdata, .arvalid, .araddr, .rready,
        .awready, .wready, .arready, .rvalid, .rdata,
        .tap_do, .tap_rd_seq, .tap_idx_seq, .run_done, .ss_tready, .sm_tvalid,
        .start, .data_len, .tap_we, .tap_a, .tap_di
    );

    fir_sequencer u_seq (
        .axis_clk, .axis_rst_n, .start, .data_len, .ss_tvalid, .ss_tdata, .y_full,
        .ss_tready, .tap_rd_seq, .tap_idx_seq, .data_we, .data_a, .data_di,
        .mac_clear, .mac_en, .y_push, .y_last
    );

    // Multiplies the two RAM outputs directly
    fir_mac u_mac (
        .axis_clk, .axis_rst_n, .mac_clear, .mac_en, .tap_do, .data_do, .acc
    );

    fir_y_out u_y (
        .axis_clk, .axis_rst_n, .y_push, .y_last, .acc, .sm_tready,
        .sm_tvalid, .sm_tdata, .sm_tlast, .y_full, .run_done
    );

endmodule

// ==== src/fir_y_out.sv ====
`timescale 1ns/1ps

module fir_y_out import fir_core_pkg::*; (
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  logic    y_push,
    input  logic    y_last,
    input  sample_t acc,
    input  logic    sm_tready,
    output logic    sm_tvalid,
    output sample_t sm_tdata,
    output logic    sm_tlast,
    output logic    y_full,
    output logic    run_done
);

    logic    full;   // Holder occupied
    logic    last_q;
    sample_t y_q;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n)
            full <= 1'b0;
        else if (y_push)
            full <= 1'b1; // Engine only pushes while empty
        else if (sm_tready)
            full <= 1'b0;
    end

    always_ff @(posedge axis_clk) begin
        if (y_push) begin
            y_q    <= acc;
            last_q <= y_last;
        end
    end

    assign sm_tvalid = full;
    assign sm_tdata  = y_q;
    assign sm_tlast  = full && last_q;
    assign y_full    = full;
    assign run_done  = full && last_q && sm_tready; // Last Y handshake
endmodule

// ==== verification/fir_bram_model.sv ====
`timescale 1ns/1ps

module fir_bram_model #(
    parameter int                    addr_width = 12,
    parameter int                    data_width = 32,
    parameter logic [data_width-1:0] fill       = '0 // Power-up pattern base
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wr_data,
    output logic [data_width-1:0] rd_data
);

    logic [data_width-1:0] mem [2**addr_width];

    // Every word differs, so a stale read shows up
    initial begin
        for (int i = 0; i < 2**addr_width; i++)
            mem[i] = fill ^ data_width'(i);
    end

    always @(posedge clk) begin
        if (we)
            mem[addr] <= wr_data;
        rd_data <= mem[addr]; // Read first, one cycle latency
    end

endmodule

// ==== verification/fir_clk_gen.sv ====
`timescale 1ns/1ps

module fir_clk_gen #(
    parameter int half_period  = 4,  // 8 ns clock
    parameter int reset_cycles = 16
) (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #(half_period) axis_clk = ~axis_clk;
    end

    initial begin
        axis_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1; // Released on a falling edge
    end

endmodule

// ==== verification/fir_sva.sv ====
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_sva (
    input logic                       axis_clk,
    input logic                       axis_rst_n,
    input logic                       sm_tvalid,
    input logic                       sm_tready,
    input logic [`FIR_DATA_WIDTH-1:0] sm_tdata,
    input logic                       sm_tlast,
    input logic                       tap_we,
    input logic                       tap_rd_seq,
    input logic                       rvalid,
    input logic                       rready
);

    int fail_count = 0; // Assertion failures so far

    // ------------------------------------------------------------------------
    // Y stream holds its word while back-pressured
    // ------------------------------------------------------------------------
    property y_hold;
        @(posedge axis_clk) disable iff (!axis_rst_n)
            sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast);
    endproperty
    assert property (y_hold) else begin
        $error("Y word changed or dropped before sm_tready");
        fail_count++;
    end

    // Lite tap writes never meet engine reads on the shared port
    property taps_frozen;
        @(posedge axis_clk) disable iff (!axis_rst_n) tap_we |-> !tap_rd_seq;
    endproperty
    assert property (taps_frozen) else begin
        $error("tap RAM written while the engine read it");
        fail_count++;
    end

    // Lite read data waits for rready
    property r_hold;
        @(posedge axis_clk) disable iff (!axis_rst_n) rvalid && !rready |=> rvalid;
    endproperty
    assert property (r_hold) else begin
        $error("rvalid fell before rready");
        fail_count++;
    end

endmodule

// ==== verification/fir_tb.sv ====
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_tb import fir_cfg_pkg::*; ();

    localparam int num_rows = 3;
    localparam int max_len  = 32;
    localparam int ntaps    = `FIR_NUM_TAPS;

    logic                       axis_clk, axis_rst_n;
    logic                       awvalid, wvalid, arvalid, rready, ss_tvalid, sm_tready;
    logic                       awready, wready, arready, rvalid, ss_tready, sm_tvalid, sm_tlast;
    logic [`FIR_ADDR_WIDTH-1:0] awaddr, araddr, tap_a, data_a;
    logic [`FIR_DATA_WIDTH-1:0] wdata, rdata, ss_tdata, sm_tdata;
    logic                       tap_we, data_we;
    logic [`FIR_DATA_WIDTH-1:0] tap_di, tap_do, data_di, data_do;

    // ------------------------------------------------------------------------
    // Test table of name, data_len, back-pressure and seed offset
    // ------------------------------------------------------------------------
    string row_name [num_rows] = '{"full_run", "backpressure", "short_run"};
    int    row_len  [num_rows] = '{24, 24, 5};
    bit    row_bp   [num_rows] = '{1'b0, 1'b1, 1'b0};
    int    row_seed [num_rows] = '{0, 0, 7}; // Rows 0 and 1 share taps and samples

    integer      seed;
    logic [31:0] h [ntaps];
    logic [31:0] x [max_len];
    logic [31:0] y_got [max_len];
    logic        last_got [max_len];
    int          errors, row_errors, tests_failed;

    fir_clk_gen u_clk (.axis_clk, .axis_rst_n);

    fir_bram_model #(.fill(32'hbad0_0000)) u_tap_ram (
        .clk(axis_clk), .we(tap_we), .addr(tap_a), .wr_data(tap_di), .rd_data(tap_do)
    );
    fir_bram_model #(.fill(32'hcafe_0000)) u_x_ram (
        .clk(axis_clk), .we(data_we), .addr(data_a), .wr_data(data_di), .rd_data(data_do)
    );

    fir_top DUT (.*);

    bind fir_top fir_sva u_sva (
        .axis_clk, .axis_rst_n, .sm_tvalid, .sm_tready, .sm_tdata, .sm_tlast,
        .tap_we, .tap_rd_seq, .rvalid, .rready
    );

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error %s %s: expected %h, actual %h", name, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_cond(input string name, input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("%s: %s", name, msg);
            row_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        errors += row_errors;
        if (row_errors != 0) begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, row_errors);
        end else
            $display("%s: passed", name);
    endtask

    // ------------------------------------------------------------------------
    // Lite bus tasks driven on the falling edge
    // ------------------------------------------------------------------------
    task automatic lite_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge axis_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        while (!awready) @(negedge axis_clk);
        @(negedge axis_clk); // aw done
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        while (!wready) @(negedge axis_clk);
        @(negedge axis_clk);
        wvalid = 1'b0;
    endtask

    task automatic lite_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge axis_clk);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        @(negedge axis_clk); // rready held low a cycle so rvalid must wait
        rready = 1'b1;
        while (!rvalid) @(negedge axis_clk);
        data = rdata; // Stable mid-cycle
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Streams
    // ------------------------------------------------------------------------
    task automatic send_x(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = x[i];
            while (!ss_tready) @(negedge axis_clk);
            @(negedge axis_clk); // Accepted on the posedge between
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic receive_y(input int n, input bit bp);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge axis_clk);
            sm_tready = bp ? (($random(seed) & 3) != 0) : 1'b1;
            if (sm_tready && sm_tvalid) begin
                y_got[got]    = sm_tdata;
                last_got[got] = sm_tlast;
                got++;
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    // Direct form truncated to 32 bits with zero history before the run
    function automatic logic [31:0] ref_y(input int n);
        logic [31:0] sum;
        int          k;
        sum = '0;
        for (k = 0; k < ntaps; k++)
            if (n - k >= 0)
                sum = sum + h[k] * x[n - k];
        return sum;
    endfunction

    task automatic run_row(input int r);
        logic [31:0] st;
        int          k, polls;
        string       name;
        name       = row_name[r];
        row_errors = 0;
        seed       = 23758 + row_seed[r];
        for (k = 0; k < ntaps; k++)
            h[k] = $random(seed);
        for (k = 0; k < row_len[r]; k++)
            x[k] = $random(seed);
        lite_write(`FIR_REG_LEN, row_len[r]);
        for (k = 0; k < ntaps; k++)
            lite_write(12'(`FIR_REG_TAP0 + 4 * k), h[k]);
        lite_read(`FIR_REG_LEN, st);
        check_value(name, "data_len", row_len[r], st);
        for (k = 0; k < ntaps; k++) begin
            lite_read(12'(`FIR_REG_TAP0 + 4 * k), st);
            check_value(name, $sformatf("tap %0d", k), h[k], st);
        end
        lite_write(`FIR_REG_AP, 32'h1); // ap_start
        fork
            send_x(row_len[r]);
            receive_y(row_len[r], row_bp[r]);
        join
        for (k = 0; k < row_len[r]; k++) begin
            check_value(name, $sformatf("y[%0d]", k), ref_y(k), y_got[k]);
            check_value(name, $sformatf("tlast[%0d]", k), 32'(k == row_len[r] - 1),
                        32'(last_got[k]));
        end
        check_value(name, "y[0] vs h0*x0", h[0] * x[0], y_got[0]);
        check_cond(name, !sm_tvalid, "an extra output appeared after the last one");
        st    = '0;
        polls = 0;
        while (!st[AP_DONE_BIT] && polls < 20) begin
            lite_read(`FIR_REG_AP, st);
            polls++;
        end
        check_cond(name, st[AP_DONE_BIT], "ap_done was not set after the last output");
        check_cond(name, st[AP_IDLE_BIT], "ap_idle was not set after the last output");
        lite_read(`FIR_REG_AP, st); // ap_done cleared by the previous read
        check_cond(name, !st[AP_DONE_BIT], "ap_done stayed set after it was read");
        finish_test(name);
    endtask

    initial begin
        logic [31:0] st;
        int          r;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b0;
        errors       = 0;
        tests_failed = 0;
        wait (axis_rst_n === 1'b1);
        row_errors = 0;
        lite_read(`FIR_REG_AP, st);
        check_value("reset_status", "ap_idle", 32'd1, 32'(st[AP_IDLE_BIT]));
        check_value("reset_status", "ap_done", 32'd0, 32'(st[AP_DONE_BIT]));
        finish_test("reset_status");
        for (r = 0; r < num_rows; r++)
            run_row(r);
        errors += DUT.u_sva.fail_count;
        $display("%0d tests, %0d failed, %0d check errors", num_rows + 1, tests_failed, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int total, limit, i;
        total = 0;
        for (i = 0; i < num_rows; i++)
            total += row_len[i];
        limit = 200 * total + 2000;
        repeat (limit) @(posedge axis_clk);
        $display("Watchdog: run still busy after %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
